//--- camera.sv
// Top level of the camera capture block.
// Takes the raw pixel stream and host commands, returns response bytes.
// Holds only the submodule instances and the wires between them.

`timescale 1ns/1ns

module camera (
    input  logic                  clock_spi_in,
    input  logic                  mipi_byte_reset_n,
    input  logic                  frame_valid_i,
    input  logic                  line_valid_i,
    input  camera_pkg::pixel_t    pixel_data_i,
    input  camera_pkg::byte_t     op_code_i,
    input  logic                  op_code_valid_i,
    input  logic                  operand_valid_i,
    input  camera_pkg::op_count_t operand_count_i,
    output camera_pkg::byte_t     response_o,
    output logic                  response_valid_o
);

    logic crop_frame_valid;
    logic crop_byte_valid;
    camera_pkg::byte_t crop_byte;
    logic capture_start;
    logic store_write_en;
    camera_pkg::word_addr_t store_write_addr;
    camera_pkg::word_t store_write_data;
    camera_pkg::byte_addr_t read_addr;
    camera_pkg::byte_t read_byte;
    camera_pkg::byte_t red_level, green_level, blue_level;

    pixel_crop pixel_crop_i (
        .clock_spi_in       (clock_spi_in),
        .mipi_byte_reset_n  (mipi_byte_reset_n),
        .frame_valid_i      (frame_valid_i),
        .line_valid_i       (line_valid_i),
        .pixel_data_i       (pixel_data_i),
        .crop_frame_valid_o (crop_frame_valid),
        .crop_byte_valid_o  (crop_byte_valid),
        .crop_byte_o        (crop_byte)
    );

    exposure_meter exposure_meter_i (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (frame_valid_i),
        .line_valid_i      (line_valid_i),
        .pixel_data_i      (pixel_data_i),
        .red_level_o       (red_level),
        .green_level_o     (green_level),
        .blue_level_o      (blue_level)
    );

    capture_packer capture_packer_i (
        .clock_spi_in       (clock_spi_in),
        .mipi_byte_reset_n  (mipi_byte_reset_n),
        .capture_start_i    (capture_start),
        .crop_frame_valid_i (crop_frame_valid),
        .crop_byte_valid_i  (crop_byte_valid),
        .crop_byte_i        (crop_byte),
        .store_write_en_o   (store_write_en),
        .store_write_addr_o (store_write_addr),
        .store_write_data_o (store_write_data)
    );

    frame_store frame_store_i (
        .clock_spi_in       (clock_spi_in),
        .store_write_en_i   (store_write_en),
        .store_write_addr_i (store_write_addr),
        .store_write_data_i (store_write_data),
        .read_addr_i        (read_addr),
        .read_byte_o        (read_byte)
    );

    command_decoder command_decoder_i (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .op_code_i         (op_code_i),
        .op_code_valid_i   (op_code_valid_i),
        .operand_valid_i   (operand_valid_i),
        .operand_count_i   (operand_count_i),
        .read_byte_i       (read_byte),
        .red_level_i       (red_level),
        .green_level_i     (green_level),
        .blue_level_i      (blue_level),
        .capture_start_o   (capture_start),
        .read_addr_o       (read_addr),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o)
    );

endmodule

//--- camera_checker.sv
// Response checker for the camera testbench.
// Compares the DUT response with the expected byte and valid on each
// check strobe, counts mismatches and prints the closing summary line.

`timescale 1ns/1ns

module camera_checker (
    input  logic              clock_spi_in,
    input  logic              check_i,
    input  camera_pkg::byte_t exp_byte_i,
    input  logic              exp_valid_i,
    input  camera_pkg::byte_t response_i,
    input  logic              response_valid_i,
    input  int                timeout_count_i,
    input  logic              done_i,
    output int                error_count_o
);

    int check_count = 0;
    int value_errors = 0;
    int valid_errors = 0;

    assign error_count_o = value_errors + valid_errors;

    // Outputs seen here are the ones settled since the previous edge
    always @(posedge clock_spi_in) begin
        if (check_i) begin
            check_count <= check_count + 1;
            if (response_valid_i !== exp_valid_i) begin
                $display("ERR %0t response_valid_o expected %b actual %b",
                         $time, exp_valid_i, response_valid_i);
                valid_errors <= valid_errors + 1;
            end
            if (response_i !== exp_byte_i) begin
                $display("ERR %0t response_o expected %02h actual %02h",
                         $time, exp_byte_i, response_i);
                value_errors <= value_errors + 1;
            end
        end
    end

    always @(posedge done_i) begin
        $display("checks %0d, value errors %0d, valid errors %0d, timeouts %0d",
                 check_count, value_errors, valid_errors, timeout_count_i);
    end

endmodule

//--- camera_config.svh
// Build-time constants for the camera capture block.
// Include in any module that needs the crop or metering window,
// the host op-codes or the frame store depth.

`ifndef CAMERA_CONFIG_SVH
`define CAMERA_CONFIG_SVH

// Crop window, end values are exclusive
`define CAM_CROP_X_START 2
`define CAM_CROP_X_END 10
`define CAM_CROP_Y_START 1
`define CAM_CROP_Y_END 5

// Metering window, end values are exclusive
`define CAM_METER_X_START 0
`define CAM_METER_X_END 16
`define CAM_METER_Y_START 0
`define CAM_METER_Y_END 8

// Log2 of the number of Bayer sites per channel in the metering window
`define CAM_RED_SHIFT 5
`define CAM_GREEN_SHIFT 6
`define CAM_BLUE_SHIFT 5

// Host op-codes
`define CAM_OP_CAPTURE 8'h20
`define CAM_OP_READ 8'h22
`define CAM_OP_METER 8'h25

`define CAM_STORE_WORDS 256

`endif

//--- camera_pkg.sv
// Shared types for the camera capture block.
// Modules refer to these by scoped name.

package camera_pkg;

    typedef logic [9:0] pixel_t;
    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0] word_addr_t;
    typedef logic [9:0] byte_addr_t;

    // Position within the incoming frame
    typedef logic [10:0] x_coord_t;
    typedef logic [9:0] y_coord_t;

    typedef logic [15:0] meter_sum_t;

    // Selects red, green or blue for a metering read
    typedef logic [1:0] op_count_t;

    typedef enum logic [1:0] {
        CAPTURE_IDLE,
        CAPTURE_ARMED,
        CAPTURE_ACTIVE
    } capture_state_t;

endpackage

//--- capture_packer.sv
// Capture state machine and word packer for the frame store.
// A capture request arms the machine, the next frame is captured whole.
// Four cropped bytes make one store word, the first byte in bits 7:0.

`timescale 1ns/1ns
`include "camera_config.svh"

module capture_packer (
    input  logic                   clock_spi_in,
    input  logic                   mipi_byte_reset_n,
    input  logic                   capture_start_i,
    input  logic                   crop_frame_valid_i,
    input  logic                   crop_byte_valid_i,
    input  camera_pkg::byte_t      crop_byte_i,
    output logic                   store_write_en_o,
    output camera_pkg::word_addr_t store_write_addr_o,
    output camera_pkg::word_t      store_write_data_o
);

    camera_pkg::capture_state_t state;
    camera_pkg::word_t word_shift;
    logic [1:0] byte_lane;
    logic [1:0] lane_now;
    logic frame_valid_q;
    logic frame_rise, frame_fall;
    logic capture_en;
    logic store_full;

    assign frame_rise = crop_frame_valid_i & ~frame_valid_q;
    assign frame_fall = ~crop_frame_valid_i & frame_valid_q;
    // Leftover bytes of a partial word are dropped at frame start
    assign lane_now = frame_rise ? 2'd0 : byte_lane;
    assign capture_en = crop_byte_valid_i &
                        ((state == camera_pkg::CAPTURE_ACTIVE) ||
                         ((state == camera_pkg::CAPTURE_ARMED) && frame_rise));

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state <= camera_pkg::CAPTURE_IDLE;
        end else if (capture_start_i) begin
            state <= camera_pkg::CAPTURE_ARMED;
        end else begin
            case (state)
                camera_pkg::CAPTURE_ARMED:
                    if (frame_rise) state <= camera_pkg::CAPTURE_ACTIVE;
                camera_pkg::CAPTURE_ACTIVE:
                    if (frame_fall) state <= camera_pkg::CAPTURE_IDLE;
                default:
                    state <= camera_pkg::CAPTURE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            byte_lane <= 2'd0;
            store_write_en_o <= 1'b0;
            store_write_addr_o <= '0;
            store_full <= 1'b0;
        end else begin
            frame_valid_q <= crop_frame_valid_i;
            byte_lane <= capture_en ? lane_now + 2'd1 : lane_now;
            // Word is complete once the fourth byte is shifted in
            store_write_en_o <= capture_en && (lane_now == 2'd3) && !store_full;
            if (capture_start_i) begin
                store_write_addr_o <= '0;
                store_full <= 1'b0;
            end else if (store_write_en_o) begin
                if (store_write_addr_o ==
                    camera_pkg::word_addr_t'(`CAM_STORE_WORDS - 1)) begin
                    store_full <= 1'b1;
                end else begin
                    store_write_addr_o <= store_write_addr_o + camera_pkg::word_addr_t'(1);
                end
            end
        end
    end

    // Newest byte enters at the top and moves down
    always_ff @(posedge clock_spi_in) begin
        if (capture_en) begin
            word_shift <= {crop_byte_i, word_shift[31:8]};
        end
    end

    assign store_write_data_o = word_shift;

endmodule

//--- command_decoder.sv
// Host op-code decoder.
// Starts captures, walks the read pointer through the frame store and
// returns stored bytes or metering levels one cycle after the op-code.

`timescale 1ns/1ns
`include "camera_config.svh"

module command_decoder (
    input  logic                   clock_spi_in,
    input  logic                   mipi_byte_reset_n,
    input  camera_pkg::byte_t      op_code_i,
    input  logic                   op_code_valid_i,
    input  logic                   operand_valid_i,
    input  camera_pkg::op_count_t  operand_count_i,
    input  camera_pkg::byte_t      read_byte_i,
    input  camera_pkg::byte_t      red_level_i,
    input  camera_pkg::byte_t      green_level_i,
    input  camera_pkg::byte_t      blue_level_i,
    output logic                   capture_start_o,
    output camera_pkg::byte_addr_t read_addr_o,
    output camera_pkg::byte_t      response_o,
    output logic                   response_valid_o
);

    logic operand_valid_q;
    logic operand_rise;

    assign operand_rise = operand_valid_i & ~operand_valid_q;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            operand_valid_q <= 1'b0;
            capture_start_o <= 1'b0;
            read_addr_o <= '0;
            response_o <= '0;
            response_valid_o <= 1'b0;
        end else begin
            operand_valid_q <= operand_valid_i;
            capture_start_o <= 1'b0;
            response_valid_o <= 1'b0;
            if (op_code_valid_i) begin
                case (op_code_i)
                    `CAM_OP_CAPTURE: begin
                        capture_start_o <= 1'b1;
                        read_addr_o <= '0;
                    end
                    `CAM_OP_READ: begin
                        response_o <= read_byte_i;
                        response_valid_o <= 1'b1;
                        // One byte per new operand strobe
                        if (operand_rise) begin
                            read_addr_o <= read_addr_o + camera_pkg::byte_addr_t'(1);
                        end
                    end
                    `CAM_OP_METER: begin
                        response_valid_o <= 1'b1;
                        case (operand_count_i)
                            2'd0: response_o <= red_level_i;
                            2'd1: response_o <= green_level_i;
                            2'd2: response_o <= blue_level_i;
                            default: response_o <= response_o;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- exposure_meter.sv
// Average red, green and blue levels of the raw Bayer stream.
// Sums each channel over the metering window during a frame and
// latches the averages when the frame ends. Levels read zero after reset.

`timescale 1ns/1ns
`include "camera_config.svh"

module exposure_meter (
    input  logic               clock_spi_in,
    input  logic               mipi_byte_reset_n,
    input  logic               frame_valid_i,
    input  logic               line_valid_i,
    input  camera_pkg::pixel_t pixel_data_i,
    output camera_pkg::byte_t  red_level_o,
    output camera_pkg::byte_t  green_level_o,
    output camera_pkg::byte_t  blue_level_o
);

    camera_pkg::x_coord_t x_count;
    camera_pkg::y_coord_t y_count;
    camera_pkg::meter_sum_t red_sum, green_sum, blue_sum;
    camera_pkg::meter_sum_t red_add, green_add, blue_add;
    camera_pkg::meter_sum_t pixel_value;
    logic frame_valid_q;
    logic line_valid_q;
    logic frame_start, frame_end;
    logic sample, red_site, blue_site;

    assign frame_start = frame_valid_i & ~frame_valid_q;
    assign frame_end = ~frame_valid_i & frame_valid_q;

    always_comb begin
        sample = frame_valid_i && line_valid_i &&
                 (int'(x_count) >= `CAM_METER_X_START) &&
                 (int'(x_count) <  `CAM_METER_X_END) &&
                 (int'(y_count) >= `CAM_METER_Y_START) &&
                 (int'(y_count) <  `CAM_METER_Y_END);
        // Red on even row and column, blue on odd row and column
        red_site = ~y_count[0] & ~x_count[0];
        blue_site = y_count[0] & x_count[0];
        pixel_value = camera_pkg::meter_sum_t'(pixel_data_i[9:2]);
        red_add = (sample && red_site) ? pixel_value : '0;
        blue_add = (sample && blue_site) ? pixel_value : '0;
        green_add = (sample && !red_site && !blue_site) ? pixel_value : '0;
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            frame_valid_q <= 1'b0;
            line_valid_q <= 1'b0;
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
            red_level_o <= '0;
            green_level_o <= '0;
            blue_level_o <= '0;
        end else begin
            frame_valid_q <= frame_valid_i;
            line_valid_q <= line_valid_i;
            x_count <= line_valid_i ? x_count + camera_pkg::x_coord_t'(1) : '0;
            if (!frame_valid_i) begin
                y_count <= '0;
            end else if (line_valid_q && !line_valid_i) begin
                y_count <= y_count + camera_pkg::y_coord_t'(1);
            end
            // New frame restarts the sums
            red_sum <= frame_start ? red_add : red_sum + red_add;
            green_sum <= frame_start ? green_add : green_sum + green_add;
            blue_sum <= frame_start ? blue_add : blue_sum + blue_add;
            if (frame_end) begin
                red_level_o <= camera_pkg::byte_t'(red_sum >> `CAM_RED_SHIFT);
                green_level_o <= camera_pkg::byte_t'(green_sum >> `CAM_GREEN_SHIFT);
                blue_level_o <= camera_pkg::byte_t'(blue_sum >> `CAM_BLUE_SHIFT);
            end
        end
    end

endmodule

//--- frame_store.sv
// Word-wide frame store for captured pixels.
// Written one word at a time by the packer, read one byte at a time
// through a byte pointer with a combinational read.

`timescale 1ns/1ns
`include "camera_config.svh"

module frame_store (
    input  logic                   clock_spi_in,
    input  logic                   store_write_en_i,
    input  camera_pkg::word_addr_t store_write_addr_i,
    input  camera_pkg::word_t      store_write_data_i,
    input  camera_pkg::byte_addr_t read_addr_i,
    output camera_pkg::byte_t      read_byte_o
);

    camera_pkg::word_t mem [`CAM_STORE_WORDS];
    camera_pkg::word_t read_word;
    camera_pkg::word_addr_t read_word_addr;

    always_ff @(posedge clock_spi_in) begin
        if (store_write_en_i) begin
            mem[store_write_addr_i] <= store_write_data_i;
        end
    end

    // Upper pointer bits pick the word, lower two the byte lane
    assign read_word_addr = read_addr_i[9:2];
    assign read_word = mem[read_word_addr];

    always_comb begin
        case (read_addr_i[1:0])
            2'd0: read_byte_o = read_word[7:0];
            2'd1: read_byte_o = read_word[15:8];
            2'd2: read_byte_o = read_word[23:16];
            default: read_byte_o = read_word[31:24];
        endcase
    end

endmodule

//--- pixel_crop.sv
// Crops a fixed window out of the raw pixel stream.
// Emits the top eight bits of each pixel in the window one cycle later,
// along with a frame valid delayed to line up with the bytes.

`timescale 1ns/1ns
`include "camera_config.svh"

module pixel_crop (
    input  logic               clock_spi_in,
    input  logic               mipi_byte_reset_n,
    input  logic               frame_valid_i,
    input  logic               line_valid_i,
    input  camera_pkg::pixel_t pixel_data_i,
    output logic               crop_frame_valid_o,
    output logic               crop_byte_valid_o,
    output camera_pkg::byte_t  crop_byte_o
);

    camera_pkg::x_coord_t x_count;
    camera_pkg::y_coord_t y_count;
    logic line_valid_q;
    logic in_window;

    assign in_window = (x_count >= camera_pkg::x_coord_t'(`CAM_CROP_X_START)) &&
                       (x_count <  camera_pkg::x_coord_t'(`CAM_CROP_X_END)) &&
                       (y_count >= camera_pkg::y_coord_t'(`CAM_CROP_Y_START)) &&
                       (y_count <  camera_pkg::y_coord_t'(`CAM_CROP_Y_END));

    // Column restarts every line, row counts line ends within the frame
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;
            if (line_valid_i) begin
                x_count <= x_count + camera_pkg::x_coord_t'(1);
            end else begin
                x_count <= '0;
            end
            if (!frame_valid_i) begin
                y_count <= '0;
            end else if (line_valid_q && !line_valid_i) begin
                y_count <= y_count + camera_pkg::y_coord_t'(1);
            end
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            crop_frame_valid_o <= 1'b0;
            crop_byte_valid_o <= 1'b0;
        end else begin
            crop_frame_valid_o <= frame_valid_i;
            crop_byte_valid_o <= frame_valid_i & line_valid_i & in_window;
        end
    end

    // Payload only, qualified by crop_byte_valid_o
    always_ff @(posedge clock_spi_in) begin
        crop_byte_o <= pixel_data_i[9:2];
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the camera testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module tb_camera -o sim_camera
./obj_dir/sim_camera > sim.log
cat sim.log
if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

//--- tb.f
+incdir+.
camera_pkg.sv
pixel_crop.sv
exposure_meter.sv
capture_packer.sv
frame_store.sv
command_decoder.sv
camera.sv
camera_checker.sv
tb_camera.sv

//--- tb_camera.sv
// Testbench top for the camera capture block.
// Drives Bayer frames from an LCG, keeps a reference model of the cropped
// bytes and channel averages, and applies a step table to the DUT.

`timescale 1ns/1ns
`include "camera_config.svh"

module tb_camera;

    // Step kinds
    localparam logic [7:0] K_IDLE = 8'd0;
    localparam logic [7:0] K_OP = 8'd1;
    localparam logic [7:0] K_FRAME = 8'd2;
    localparam logic [7:0] K_PULSE = 8'd3;
    localparam logic [7:0] K_EXPECT = 8'd4;
    // Sources of an expected response
    localparam logic [7:0] E_NONE = 8'd0;
    localparam logic [7:0] E_READ = 8'd1;
    localparam logic [7:0] E_RED = 8'd2;
    localparam logic [7:0] E_GREEN = 8'd3;
    localparam logic [7:0] E_BLUE = 8'd4;
    localparam logic [7:0] NO_CAPTURE = 8'hff;
    localparam int ROWS = 8;
    localparam int COLS = 16;
    localparam int VALID_TIMEOUT = 20;

    logic clock_spi_in;
    logic mipi_byte_reset_n;
    logic frame_valid_i;
    logic line_valid_i;
    camera_pkg::pixel_t pixel_data_i;
    camera_pkg::byte_t op_code_i;
    logic op_code_valid_i;
    logic operand_valid_i;
    camera_pkg::op_count_t operand_count_i;
    camera_pkg::byte_t response_o;
    logic response_valid_o;

    logic check_strobe;
    logic exp_valid;
    camera_pkg::byte_t exp_byte;
    logic done;
    int timeout_count;
    int error_count;

    // Reference model state
    logic [31:0] rand_state;
    camera_pkg::pixel_t frame_pix [ROWS][COLS];
    camera_pkg::byte_t cap_bytes [32];
    camera_pkg::byte_t red_level, green_level, blue_level;
    camera_pkg::byte_t last_resp;
    logic model_armed;
    int read_ptr;
    logic [23:0] step_table [64];
    int step_count;

    camera camera_i (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (frame_valid_i),
        .line_valid_i      (line_valid_i),
        .pixel_data_i      (pixel_data_i),
        .op_code_i         (op_code_i),
        .op_code_valid_i   (op_code_valid_i),
        .operand_valid_i   (operand_valid_i),
        .operand_count_i   (operand_count_i),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o)
    );

    camera_checker checker_i (
        .clock_spi_in     (clock_spi_in),
        .check_i          (check_strobe),
        .exp_byte_i       (exp_byte),
        .exp_valid_i      (exp_valid),
        .response_i       (response_o),
        .response_valid_i (response_valid_o),
        .timeout_count_i  (timeout_count),
        .done_i           (done),
        .error_count_o    (error_count)
    );

    always #2 clock_spi_in = ~clock_spi_in;

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_step(input logic [7:0] kind, input logic [7:0] code,
                            input logic [7:0] count);
        step_table[step_count] = {kind, code, count};
        step_count++;
    endtask

    // Crop bytes in raster order and per-site averages of the last frame
    task automatic build_model(input logic take);
        int r, c, k, ch;
        int sum [3];
        int cnt [3];
        for (ch = 0; ch < 3; ch++) begin
            sum[ch] = 0;
            cnt[ch] = 0;
        end
        for (r = 0; r < ROWS; r++) begin
            for (c = 0; c < COLS; c++) begin
                ch = (r % 2 == 0 && c % 2 == 0) ? 0 : (r % 2 == 1 && c % 2 == 1) ? 2 : 1;
                sum[ch] += int'(frame_pix[r][c][9:2]);
                cnt[ch]++;
            end
        end
        red_level = 8'(sum[0] / cnt[0]);
        green_level = 8'(sum[1] / cnt[1]);
        blue_level = 8'(sum[2] / cnt[2]);
        if (take) begin
            k = 0;
            for (r = `CAM_CROP_Y_START; r < `CAM_CROP_Y_END; r++) begin
                for (c = `CAM_CROP_X_START; c < `CAM_CROP_X_END; c++) begin
                    cap_bytes[k] = frame_pix[r][c][9:2];
                    k++;
                end
            end
        end
    endtask

    // Capture request can be slipped in at the first pixel of a chosen row
    task automatic send_frame(input int cap_row);
        int r, c;
        logic take;
        take = model_armed;
        model_armed = 1'b0;
        frame_valid_i = 1'b1;
        @(negedge clock_spi_in);
        for (r = 0; r < ROWS; r++) begin
            for (c = 0; c < COLS; c++) begin
                rand_state = next_rand(rand_state);
                line_valid_i = 1'b1;
                pixel_data_i = rand_state[25:16];
                frame_pix[r][c] = rand_state[25:16];
                if (r == cap_row && c == 0) begin
                    op_code_i = `CAM_OP_CAPTURE;
                    op_code_valid_i = 1'b1;
                    model_armed = 1'b1;
                    read_ptr = 0;
                end else if (r == cap_row && c == 1) begin
                    op_code_valid_i = 1'b0;
                end
                @(negedge clock_spi_in);
            end
            line_valid_i = 1'b0;
            repeat (2) @(negedge clock_spi_in);
        end
        frame_valid_i = 1'b0;
        repeat (4) @(negedge clock_spi_in);
        build_model(take);
    endtask

    task automatic drive_op(input logic [7:0] code, input logic [7:0] count);
        op_code_i = code;
        operand_count_i = count[1:0];
        op_code_valid_i = 1'b1;
        if (code == `CAM_OP_CAPTURE) begin
            model_armed = 1'b1;
            read_ptr = 0;
        end
        @(negedge clock_spi_in);
    endtask

    task automatic pulse_operand();
        operand_valid_i = 1'b1;
        @(negedge clock_spi_in);
        operand_valid_i = 1'b0;
        read_ptr++;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (response_valid_o !== 1'b1 && n < VALID_TIMEOUT) begin
            @(negedge clock_spi_in);
            n++;
        end
        if (response_valid_o !== 1'b1) begin
            $display("Timeout at %0t: response_valid_o never went high", $time);
            timeout_count++;
        end
    endtask

    // With no response expected, the byte must hold its last value
    task automatic expect_response(input logic [7:0] src);
        camera_pkg::byte_t value;
        logic valid;
        valid = 1'b1;
        case (src)
            E_READ: value = cap_bytes[read_ptr];
            E_RED: value = red_level;
            E_GREEN: value = green_level;
            E_BLUE: value = blue_level;
            default: begin
                value = last_resp;
                valid = 1'b0;
            end
        endcase
        last_resp = value;
        repeat (2) @(negedge clock_spi_in);
        if (valid) begin
            wait_valid();
        end
        exp_byte = value;
        exp_valid = valid;
        check_strobe = 1'b1;
        @(negedge clock_spi_in);
        check_strobe = 1'b0;
    endtask

    initial begin
        int i;
        logic [7:0] kind, code, count;
        clock_spi_in = 1'b0;
        mipi_byte_reset_n = 1'b0;
        frame_valid_i = 1'b0;
        line_valid_i = 1'b0;
        pixel_data_i = '0;
        op_code_i = '0;
        op_code_valid_i = 1'b0;
        operand_valid_i = 1'b0;
        operand_count_i = '0;
        check_strobe = 1'b0;
        exp_valid = 1'b0;
        exp_byte = '0;
        done = 1'b0;
        timeout_count = 0;
        rand_state = 32'hdd50;
        model_armed = 1'b0;
        read_ptr = 0;
        last_resp = '0;
        step_count = 0;

        // Reset state, then metering of a plain frame
        add_step(K_IDLE, 8'h00, 8'd0);
        add_step(K_EXPECT, E_NONE, 8'd0);
        add_step(K_FRAME, 8'h00, NO_CAPTURE);
        add_step(K_EXPECT, E_NONE, 8'd0);
        add_step(K_OP, `CAM_OP_METER, 8'd0);
        add_step(K_EXPECT, E_RED, 8'd0);
        add_step(K_OP, `CAM_OP_METER, 8'd1);
        add_step(K_EXPECT, E_GREEN, 8'd0);
        add_step(K_OP, `CAM_OP_METER, 8'd2);
        add_step(K_EXPECT, E_BLUE, 8'd0);
        // Capture one frame and read it back
        add_step(K_OP, `CAM_OP_CAPTURE, 8'd0);
        add_step(K_IDLE, 8'h00, 8'd0);
        add_step(K_FRAME, 8'h00, NO_CAPTURE);
        add_step(K_OP, `CAM_OP_READ, 8'd0);
        add_step(K_EXPECT, E_READ, 8'd0);
        add_step(K_PULSE, 8'h00, 8'd31);
        add_step(K_OP, 8'h30, 8'd0);
        add_step(K_EXPECT, E_NONE, 8'd0);
        add_step(K_IDLE, 8'h00, 8'd0);
        add_step(K_EXPECT, E_NONE, 8'd0);
        // Capture during a frame lands on the next one
        add_step(K_FRAME, 8'h00, 8'd3);
        add_step(K_FRAME, 8'h00, NO_CAPTURE);
        add_step(K_OP, `CAM_OP_READ, 8'd0);
        add_step(K_EXPECT, E_READ, 8'd0);
        add_step(K_PULSE, 8'h00, 8'd31);
        add_step(K_OP, `CAM_OP_METER, 8'd1);
        add_step(K_EXPECT, E_GREEN, 8'd0);
        add_step(K_IDLE, 8'h00, 8'd0);
        add_step(K_EXPECT, E_NONE, 8'd0);

        repeat (5) @(negedge clock_spi_in);
        mipi_byte_reset_n = 1'b1;

        for (i = 0; i < step_count; i++) begin
            kind = step_table[i][23:16];
            code = step_table[i][15:8];
            count = step_table[i][7:0];
            case (kind)
                K_IDLE: begin
                    op_code_valid_i = 1'b0;
                    @(negedge clock_spi_in);
                end
                K_OP: drive_op(code, count);
                K_FRAME: send_frame(int'(count));
                K_PULSE: begin
                    repeat (count) begin
                        pulse_operand();
                        expect_response(E_READ);
                    end
                end
                default: expect_response(code);
            endcase
        end

        done = 1'b1;
        #1;
        if (error_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
